/* rtl/isa_pkg.sv */
package isa_pkg;

    // ------------------------------------------------------------------
    // register model
    // ------------------------------------------------------------------
    localparam int num_regs = 32;

    typedef logic [31:0] word_t;
    typedef logic [$clog2(num_regs)-1:0] reg_idx_t;

    // coprocessor 0 holds only the interrupt enable and the exception pc
    typedef enum logic {
        CP0_IE  = 1'b0,
        CP0_EPC = 1'b1
    } cp0_sel_t;

    // ------------------------------------------------------------------
    // operations
    // ------------------------------------------------------------------
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_ADDI = 4'd5,    // rs plus sign extended immediate
        OP_LUI  = 4'd6,
        OP_MFC0 = 4'd7,
        OP_MTC0 = 4'd8     // rt goes to the selected cp0 register
    } op_t;

endpackage

/* rtl/fwd_pkg.sv */
package fwd_pkg;

    // register operand source for the EX stage
    typedef enum logic [1:0] {
        FWD_RF_NORM = 2'd0,    // value read at issue
        FWD_RF_TMP  = 2'd1,    // result sitting in MA
        FWD_RF_DAT  = 2'd2     // result sitting in WB
    } fwd_rf_sel_t;

    // cp0 value source, named after the stage that produced the pending write
    typedef enum logic [1:0] {
        FWD_RC0_NORM = 2'd0,
        FWD_RC0_EX   = 2'd1,
        FWD_RC0_MA   = 2'd2
    } fwd_rc0_sel_t;

    // ------------------------------------------------------------------
    // stage records
    // ------------------------------------------------------------------
    typedef struct packed {
        isa_pkg::op_t      op;
        isa_pkg::reg_idx_t rs;
        isa_pkg::reg_idx_t rt;
        isa_pkg::reg_idx_t rd;
        logic [15:0]       imm;
        isa_pkg::cp0_sel_t cp0_sel;
        isa_pkg::word_t    rf_a;
        isa_pkg::word_t    rf_b;
        isa_pkg::word_t    ie;
        isa_pkg::word_t    epc;
    } ex_entry_t;

    typedef struct packed {
        logic              rf_we;
        isa_pkg::reg_idx_t rd;
        isa_pkg::word_t    result;
        logic              cp0_we;
        isa_pkg::cp0_sel_t cp0_sel;
        isa_pkg::word_t    cp0_data;
    } res_entry_t;

endpackage

/* rtl/arch_regs.sv */
module arch_regs #(
    parameter int data_width = 32
) (
    input  logic                    clk,
    input  logic                    reset,
    input  isa_pkg::reg_idx_t       rd_a_idx,
    input  isa_pkg::reg_idx_t       rd_b_idx,
    output logic [data_width-1:0]   rd_a_data,
    output logic [data_width-1:0]   rd_b_data,
    input  logic                    rf_we,
    input  isa_pkg::reg_idx_t       rf_w_idx,
    input  logic [data_width-1:0]   rf_w_data,
    input  logic                    cp0_we,
    input  isa_pkg::cp0_sel_t       cp0_w_sel,
    input  logic [data_width-1:0]   cp0_w_data,
    output logic [data_width-1:0]   ie,
    output logic [data_width-1:0]   epc
);
    import isa_pkg::*;

    logic [data_width-1:0] regs [num_regs];
    logic [data_width-1:0] ie_q;
    logic [data_width-1:0] epc_q;

    logic gpr_write;
    assign gpr_write = rf_we && (rf_w_idx != '0);    // r0 swallows its writes

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (gpr_write) begin
            regs[rf_w_idx] <= rf_w_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ie_q  <= '0;
            epc_q <= '0;
        end else if (cp0_we) begin
            if (cp0_w_sel == CP0_IE) ie_q <= cp0_w_data;
            else epc_q <= cp0_w_data;
        end
    end

    // ------------------------------------------------------------------
    // reads see a write landing on the same edge
    // ------------------------------------------------------------------
    assign rd_a_data = (rd_a_idx == '0) ? '0 :
                       (gpr_write && rf_w_idx == rd_a_idx) ? rf_w_data : regs[rd_a_idx];
    assign rd_b_data = (rd_b_idx == '0) ? '0 :
                       (gpr_write && rf_w_idx == rd_b_idx) ? rf_w_data : regs[rd_b_idx];

    assign ie  = (cp0_we && cp0_w_sel == CP0_IE) ? cp0_w_data : ie_q;
    assign epc = (cp0_we && cp0_w_sel == CP0_EPC) ? cp0_w_data : epc_q;

endmodule

/* rtl/fwd_ctrl.sv */
module fwd_ctrl (
    input  logic                  ex_valid,
    input  isa_pkg::reg_idx_t     ex_rs,
    input  isa_pkg::reg_idx_t     ex_rt,
    input  isa_pkg::cp0_sel_t     ex_cp0_sel,
    input  logic                  ma_valid,
    input  logic                  ma_rf_we,
    input  isa_pkg::reg_idx_t     ma_rd,
    input  logic                  ma_cp0_we,
    input  isa_pkg::cp0_sel_t     ma_cp0_sel,
    input  logic                  wb_valid,
    input  logic                  wb_rf_we,
    input  isa_pkg::reg_idx_t     wb_rd,
    input  logic                  wb_cp0_we,
    input  isa_pkg::cp0_sel_t     wb_cp0_sel,
    output fwd_pkg::fwd_rf_sel_t  sel_rf_a,
    output fwd_pkg::fwd_rf_sel_t  sel_rf_b,
    output fwd_pkg::fwd_rc0_sel_t sel_rc0_ie,
    output fwd_pkg::fwd_rc0_sel_t sel_rc0_epc
);
    import isa_pkg::*;
    import fwd_pkg::*;

    logic ma_rf_live;
    logic wb_rf_live;
    logic ma_c0_live;
    logic wb_c0_live;

    // a stage only counts as a source while it holds a real write
    assign ma_rf_live = ex_valid && ma_valid && ma_rf_we && (ma_rd != '0);
    assign wb_rf_live = ex_valid && wb_valid && wb_rf_we && (wb_rd != '0);
    assign ma_c0_live = ex_valid && ma_valid && ma_cp0_we;
    assign wb_c0_live = ex_valid && wb_valid && wb_cp0_we;

    // ------------------------------------------------------------------
    // general registers, the younger MA result wins over WB
    // ------------------------------------------------------------------
    assign sel_rf_a = (ma_rf_live && ma_rd == ex_rs) ? FWD_RF_TMP :
                      (wb_rf_live && wb_rd == ex_rs) ? FWD_RF_DAT : FWD_RF_NORM;
    assign sel_rf_b = (ma_rf_live && ma_rd == ex_rt) ? FWD_RF_TMP :
                      (wb_rf_live && wb_rd == ex_rt) ? FWD_RF_DAT : FWD_RF_NORM;

    // ------------------------------------------------------------------
    // cp0, only the register the EX instruction reads is redirected
    // ------------------------------------------------------------------
    logic rd_ie;
    logic rd_epc;
    assign rd_ie  = (ex_cp0_sel == CP0_IE);
    assign rd_epc = (ex_cp0_sel == CP0_EPC);

    assign sel_rc0_ie = (rd_ie && ma_c0_live && ma_cp0_sel == CP0_IE) ? FWD_RC0_EX :
                        (rd_ie && wb_c0_live && wb_cp0_sel == CP0_IE) ? FWD_RC0_MA :
                        FWD_RC0_NORM;
    assign sel_rc0_epc = (rd_epc && ma_c0_live && ma_cp0_sel == CP0_EPC) ? FWD_RC0_EX :
                         (rd_epc && wb_c0_live && wb_cp0_sel == CP0_EPC) ? FWD_RC0_MA :
                         FWD_RC0_NORM;

endmodule

/* rtl/cmb_forward.sv */
module cmb_forward #(
    parameter int data_width = 32
) (
    input  fwd_pkg::fwd_rf_sel_t  sel_rf_a,
    input  fwd_pkg::fwd_rf_sel_t  sel_rf_b,
    input  fwd_pkg::fwd_rc0_sel_t sel_rc0_ie,
    input  fwd_pkg::fwd_rc0_sel_t sel_rc0_epc,
    input  logic [data_width-1:0] ex_rf_data_a,
    input  logic [data_width-1:0] ex_rf_data_b,
    input  logic [data_width-1:0] ex_rc0_ie,
    input  logic [data_width-1:0] ex_rc0_epc,
    input  logic [data_width-1:0] ma_result,
    input  logic [data_width-1:0] wb_result,
    input  logic [data_width-1:0] ma_cp0_data,
    input  logic [data_width-1:0] wb_cp0_data,
    input  isa_pkg::cp0_sel_t     ma_cp0_sel,
    input  isa_pkg::cp0_sel_t     wb_cp0_sel,
    output logic [data_width-1:0] fwd_rf_a,
    output logic [data_width-1:0] fwd_rf_b,
    output logic [data_width-1:0] fwd_rc0_ie,
    output logic [data_width-1:0] fwd_rc0_epc
);
    import isa_pkg::*;
    import fwd_pkg::*;

    // split each stage's single cp0 write into per-register values
    logic [data_width-1:0] ma_ie_w, ma_epc_w, wb_ie_w, wb_epc_w;
    assign ma_ie_w  = (ma_cp0_sel == CP0_IE) ? ma_cp0_data : ex_rc0_ie;
    assign ma_epc_w = (ma_cp0_sel == CP0_EPC) ? ma_cp0_data : ex_rc0_epc;
    assign wb_ie_w  = (wb_cp0_sel == CP0_IE) ? wb_cp0_data : ex_rc0_ie;
    assign wb_epc_w = (wb_cp0_sel == CP0_EPC) ? wb_cp0_data : ex_rc0_epc;

    always_comb begin
        case (sel_rf_a)
            FWD_RF_TMP: fwd_rf_a = ma_result;
            FWD_RF_DAT: fwd_rf_a = wb_result;
            default:    fwd_rf_a = ex_rf_data_a;
        endcase
        case (sel_rf_b)
            FWD_RF_TMP: fwd_rf_b = ma_result;
            FWD_RF_DAT: fwd_rf_b = wb_result;
            default:    fwd_rf_b = ex_rf_data_b;
        endcase
        case (sel_rc0_ie)
            FWD_RC0_EX: fwd_rc0_ie = ma_ie_w;
            FWD_RC0_MA: fwd_rc0_ie = wb_ie_w;
            default:    fwd_rc0_ie = ex_rc0_ie;
        endcase
        case (sel_rc0_epc)
            FWD_RC0_EX: fwd_rc0_epc = ma_epc_w;
            FWD_RC0_MA: fwd_rc0_epc = wb_epc_w;
            default:    fwd_rc0_epc = ex_rc0_epc;
        endcase
    end

endmodule

/* rtl/pipe_reg.sv */
module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     advance,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    // ------------------------------------------------------------------
    // occupancy
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= in_valid;    // an empty upstream stage loads a bubble
        end
    end

    // ------------------------------------------------------------------
    // payload, meaningless while out_valid is low
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (advance) begin
            out_data <= in_data;
        end
    end

endmodule

/* rtl/exec_unit.sv */
module exec_unit #(
    parameter int data_width = 32
) (
    input  isa_pkg::op_t          op,
    input  isa_pkg::reg_idx_t     rd,
    input  logic [15:0]           imm,
    input  isa_pkg::cp0_sel_t     cp0_sel,
    input  logic [data_width-1:0] opnd_a,
    input  logic [data_width-1:0] opnd_b,
    input  logic [data_width-1:0] cp0_ie,
    input  logic [data_width-1:0] cp0_epc,
    output logic                  rf_we,
    output isa_pkg::reg_idx_t     rd_out,
    output logic [data_width-1:0] result,
    output logic                  cp0_we,
    output logic [data_width-1:0] cp0_data
);
    import isa_pkg::*;

    logic [data_width-1:0] imm_sext;
    logic [data_width-1:0] imm_upper;

    assign imm_sext  = {{(data_width-16){imm[15]}}, imm};
    assign imm_upper = {imm, {(data_width-16){1'b0}}};

    always_comb begin
        rf_we    = 1'b1;
        rd_out   = rd;
        result   = '0;
        cp0_we   = 1'b0;
        cp0_data = opnd_b;    // only meaningful for MTC0
        case (op)
            OP_ADD:  result = opnd_a + opnd_b;
            OP_SUB:  result = opnd_a - opnd_b;
            OP_AND:  result = opnd_a & opnd_b;
            OP_OR:   result = opnd_a | opnd_b;
            OP_XOR:  result = opnd_a ^ opnd_b;
            OP_ADDI: result = opnd_a + imm_sext;
            OP_LUI:  result = imm_upper;
            OP_MFC0: result = (cp0_sel == CP0_IE) ? cp0_ie : cp0_epc;
            OP_MTC0: begin
                // the retire port still shows the moved value
                rf_we  = 1'b0;
                rd_out = '0;
                result = opnd_b;
                cp0_we = 1'b1;
            end
            default: begin
                rf_we  = 1'b0;
                rd_out = '0;
            end
        endcase
    end

endmodule

/* rtl/operand_core.sv */
module operand_core #(
    parameter int data_width = 32
) (
    input  logic                  clk,
    input  logic                  reset,
    // issue side
    input  logic                  in_valid,
    output logic                  in_ready,
    input  isa_pkg::op_t          in_op,
    input  isa_pkg::reg_idx_t     in_rs,
    input  isa_pkg::reg_idx_t     in_rt,
    input  isa_pkg::reg_idx_t     in_rd,
    input  logic [15:0]           in_imm,
    input  isa_pkg::cp0_sel_t     in_cp0_sel,
    // retire side
    output logic                  ret_valid,
    input  logic                  ret_ready,
    output isa_pkg::reg_idx_t     ret_rd,
    output logic [data_width-1:0] ret_data,
    output logic                  ret_cp0_we
);
    import isa_pkg::*;
    import fwd_pkg::*;

    logic advance;
    logic retire;

    ex_entry_t  ex_in, ex_q;
    res_entry_t ma_in, ma_q, wb_q;
    logic       ex_valid, ma_valid, wb_valid;

    logic [data_width-1:0] rf_a_data, rf_b_data, ie, epc;
    logic [data_width-1:0] fwd_a, fwd_b, fwd_ie, fwd_epc;

    fwd_rf_sel_t  sel_rf_a, sel_rf_b;
    fwd_rc0_sel_t sel_rc0_ie, sel_rc0_epc;

    logic                  ex_rf_we, ex_cp0_we;
    reg_idx_t              ex_rd;
    logic [data_width-1:0] ex_result, ex_cp0_data;

    // the whole pipe moves as one, held only by the retire port
    assign advance  = !wb_valid || ret_ready;
    assign in_ready = advance;
    assign retire   = wb_valid && ret_ready;

    // ------------------------------------------------------------------
    // issue, operands are read while the instruction is offered
    // ------------------------------------------------------------------
    arch_regs #(.data_width(data_width)) u_arch_regs (
        .clk(clk), .reset(reset),
        .rd_a_idx(in_rs), .rd_b_idx(in_rt),
        .rd_a_data(rf_a_data), .rd_b_data(rf_b_data),
        .rf_we(retire && wb_q.rf_we), .rf_w_idx(wb_q.rd), .rf_w_data(wb_q.result),
        .cp0_we(retire && wb_q.cp0_we), .cp0_w_sel(wb_q.cp0_sel),
        .cp0_w_data(wb_q.cp0_data),
        .ie(ie), .epc(epc)
    );

    always_comb begin
        ex_in.op      = in_op;
        ex_in.rs      = in_rs;
        ex_in.rt      = in_rt;
        ex_in.rd      = in_rd;
        ex_in.imm     = in_imm;
        ex_in.cp0_sel = in_cp0_sel;
        ex_in.rf_a    = rf_a_data;
        ex_in.rf_b    = rf_b_data;
        ex_in.ie      = ie;
        ex_in.epc     = epc;
    end

    pipe_reg #(.payload_t(ex_entry_t)) ex_stage (
        .clk(clk), .reset(reset), .advance(advance),
        .in_valid(in_valid), .in_data(ex_in),
        .out_valid(ex_valid), .out_data(ex_q)
    );

    // ------------------------------------------------------------------
    // execute with forwarded operands
    // ------------------------------------------------------------------
    fwd_ctrl u_fwd_ctrl (
        .ex_valid(ex_valid), .ex_rs(ex_q.rs), .ex_rt(ex_q.rt), .ex_cp0_sel(ex_q.cp0_sel),
        .ma_valid(ma_valid), .ma_rf_we(ma_q.rf_we), .ma_rd(ma_q.rd),
        .ma_cp0_we(ma_q.cp0_we), .ma_cp0_sel(ma_q.cp0_sel),
        .wb_valid(wb_valid), .wb_rf_we(wb_q.rf_we), .wb_rd(wb_q.rd),
        .wb_cp0_we(wb_q.cp0_we), .wb_cp0_sel(wb_q.cp0_sel),
        .sel_rf_a(sel_rf_a), .sel_rf_b(sel_rf_b),
        .sel_rc0_ie(sel_rc0_ie), .sel_rc0_epc(sel_rc0_epc)
    );

    cmb_forward #(.data_width(data_width)) u_cmb_forward (
        .sel_rf_a(sel_rf_a), .sel_rf_b(sel_rf_b),
        .sel_rc0_ie(sel_rc0_ie), .sel_rc0_epc(sel_rc0_epc),
        .ex_rf_data_a(ex_q.rf_a), .ex_rf_data_b(ex_q.rf_b),
        .ex_rc0_ie(ex_q.ie), .ex_rc0_epc(ex_q.epc),
        .ma_result(ma_q.result), .wb_result(wb_q.result),
        .ma_cp0_data(ma_q.cp0_data), .wb_cp0_data(wb_q.cp0_data),
        .ma_cp0_sel(ma_q.cp0_sel), .wb_cp0_sel(wb_q.cp0_sel),
        .fwd_rf_a(fwd_a), .fwd_rf_b(fwd_b),
        .fwd_rc0_ie(fwd_ie), .fwd_rc0_epc(fwd_epc)
    );

    exec_unit #(.data_width(data_width)) u_exec_unit (
        .op(ex_q.op), .rd(ex_q.rd), .imm(ex_q.imm), .cp0_sel(ex_q.cp0_sel),
        .opnd_a(fwd_a), .opnd_b(fwd_b), .cp0_ie(fwd_ie), .cp0_epc(fwd_epc),
        .rf_we(ex_rf_we), .rd_out(ex_rd), .result(ex_result),
        .cp0_we(ex_cp0_we), .cp0_data(ex_cp0_data)
    );

    always_comb begin
        ma_in.rf_we    = ex_rf_we;
        ma_in.rd       = ex_rd;
        ma_in.result   = ex_result;
        ma_in.cp0_we   = ex_cp0_we;
        ma_in.cp0_sel  = ex_q.cp0_sel;
        ma_in.cp0_data = ex_cp0_data;
    end

    // ------------------------------------------------------------------
    // MA and WB only carry results toward the retire port
    // ------------------------------------------------------------------
    pipe_reg #(.payload_t(res_entry_t)) ma_stage (
        .clk(clk), .reset(reset), .advance(advance),
        .in_valid(ex_valid), .in_data(ma_in),
        .out_valid(ma_valid), .out_data(ma_q)
    );

    pipe_reg #(.payload_t(res_entry_t)) wb_stage (
        .clk(clk), .reset(reset), .advance(advance),
        .in_valid(ma_valid), .in_data(ma_q),
        .out_valid(wb_valid), .out_data(wb_q)
    );

    assign ret_valid  = wb_valid;
    assign ret_rd     = wb_q.rd;
    assign ret_data   = wb_q.result;
    assign ret_cp0_we = wb_q.cp0_we;

endmodule

/* tests/operand_core_asserts.sv */
module operand_core_asserts #(
    parameter int data_width = 32
) (
    input logic                  clk,
    input logic                  reset,
    input logic                  in_valid,
    input logic                  in_ready,
    input logic                  ex_valid,
    input logic                  ma_valid,
    input logic                  ret_valid,
    input logic                  ret_ready,
    input isa_pkg::reg_idx_t     ret_rd,
    input logic [data_width-1:0] ret_data
);

    // the pipe comes out of reset empty
    assert property (@(posedge clk) reset |=> !ret_valid)
        else $error("ret_valid high right after a reset cycle");

    // a held retire keeps its payload until it is taken
    assert property (@(posedge clk) disable iff (reset)
        (ret_valid && !ret_ready) |=> (ret_valid && $stable(ret_rd) && $stable(ret_data)))
        else $error("retire payload moved while ret_ready was low");

    // an open in_ready means every stage took its upstream value on that edge
    assert property (@(posedge clk) disable iff (reset)
        in_ready |=> (ex_valid == $past(in_valid) && ma_valid == $past(ex_valid) &&
                      ret_valid == $past(ma_valid)))
        else $error("stages did not shift on an edge where in_ready was high");

    // a closed in_ready freezes the whole pipe
    assert property (@(posedge clk) disable iff (reset)
        !in_ready |=> (ex_valid == $past(ex_valid) && ma_valid == $past(ma_valid) &&
                       ret_valid))
        else $error("stages moved on an edge where in_ready was low");

endmodule

bind operand_core operand_core_asserts #(.data_width(data_width)) u_asserts (
    .clk(clk), .reset(reset), .in_valid(in_valid), .in_ready(in_ready),
    .ex_valid(ex_valid), .ma_valid(ma_valid),
    .ret_valid(ret_valid), .ret_ready(ret_ready), .ret_rd(ret_rd), .ret_data(ret_data)
);

/* tests/operand_core_tb.sv */
module operand_core_tb;
    import isa_pkg::*;

    logic        clk = 1'b0;
    logic        reset;
    logic        in_valid;
    logic        in_ready;
    op_t         in_op;
    reg_idx_t    in_rs;
    reg_idx_t    in_rt;
    reg_idx_t    in_rd;
    logic [15:0] in_imm;
    cp0_sel_t    in_cp0_sel;
    logic        ret_valid;
    logic        ret_ready = 1'b0;
    reg_idx_t    ret_rd;
    word_t       ret_data;
    logic        ret_cp0_we;

    integer seed = 32'h3b50_7807;
    int     errors = 0;
    int     checks = 0;
    int     retired = 0;
    int     n_instr = 0;
    logic   loaded = 1'b0;

    // issue side of each trace line
    logic [3:0]  st_op [$];
    reg_idx_t    st_rs [$];
    reg_idx_t    st_rt [$];
    reg_idx_t    st_rd [$];
    logic [15:0] st_imm [$];
    logic        st_sel [$];

    // expected retire values, in trace order
    reg_idx_t    exp_rd [$];
    word_t       exp_data [$];
    logic        exp_cp0_we [$];

    // last retire values seen while the port was stalled
    logic        held = 1'b0;
    reg_idx_t    held_rd;
    word_t       held_data;

    operand_core #(.data_width(32)) DUT (
        .clk(clk), .reset(reset),
        .in_valid(in_valid), .in_ready(in_ready), .in_op(in_op),
        .in_rs(in_rs), .in_rt(in_rt), .in_rd(in_rd),
        .in_imm(in_imm), .in_cp0_sel(in_cp0_sel),
        .ret_valid(ret_valid), .ret_ready(ret_ready), .ret_rd(ret_rd),
        .ret_data(ret_data), .ret_cp0_we(ret_cp0_we)
    );

    always #20 clk = ~clk;

    always @(negedge clk) begin
        ret_ready = (($random(seed) & 3) != 0);    // ready about three cycles in four
    end

    task automatic end_run;
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    // ------------------------------------------------------------------
    // retire monitor
    // ------------------------------------------------------------------
    always @(posedge clk) begin
        if (!reset && held) begin
            assert (ret_rd == held_rd) else begin
                errors++;
                $display("ERROR at %0t: ret_rd = %h under stall, held %h", $time, ret_rd, held_rd);
            end
            assert (ret_data == held_data) else begin
                errors++;
                $display("ERROR at %0t: ret_data = %h under stall, held %h",
                         $time, ret_data, held_data);
            end
        end
        held      = !reset && ret_valid && !ret_ready;
        held_rd   = ret_rd;
        held_data = ret_data;
        if (!reset && ret_valid && ret_ready) begin
            if (exp_rd.size() == 0) begin
                errors++;
                $display("extra instruction retired at %0t beyond the end of the trace", $time);
            end else begin
                checks++;
                assert (ret_rd == exp_rd[0]) else begin
                    errors++;
                    $display("ERROR at %0t: ret_rd = %h, expected %h", $time, ret_rd, exp_rd[0]);
                end
                assert (ret_data == exp_data[0]) else begin
                    errors++;
                    $display("ERROR at %0t: ret_data = %h, expected %h",
                             $time, ret_data, exp_data[0]);
                end
                assert (ret_cp0_we == exp_cp0_we[0]) else begin
                    errors++;
                    $display("ERROR at %0t: ret_cp0_we = %b, expected %b",
                             $time, ret_cp0_we, exp_cp0_we[0]);
                end
                void'(exp_rd.pop_front());
                void'(exp_data.pop_front());
                void'(exp_cp0_we.pop_front());
                retired++;
            end
        end
    end

    // ------------------------------------------------------------------
    // trace load and issue
    // ------------------------------------------------------------------
    initial begin
        int          fd;
        int          code;
        string       line;
        logic [31:0] col [9];
        reset      = 1'b1;
        in_valid   = 1'b0;
        in_op      = OP_ADD;
        in_rs      = '0;
        in_rt      = '0;
        in_rd      = '0;
        in_imm     = '0;
        in_cp0_sel = CP0_IE;
        fd = $fopen("tests/operand_trace.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the trace file tests/operand_trace.txt");
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0 && line[0] != "#" &&
                    $sscanf(line, "%h %h %h %h %h %h %h %h %h", col[0], col[1], col[2],
                            col[3], col[4], col[5], col[6], col[7], col[8]) == 9) begin
                    st_op.push_back(col[0][3:0]);
                    st_rs.push_back(col[1][4:0]);
                    st_rt.push_back(col[2][4:0]);
                    st_rd.push_back(col[3][4:0]);
                    st_imm.push_back(col[4][15:0]);
                    st_sel.push_back(col[5][0]);
                    exp_rd.push_back(col[6][4:0]);
                    exp_data.push_back(col[7]);
                    exp_cp0_we.push_back(col[8][0]);
                end
            end
            $fclose(fd);
        end
        n_instr = st_op.size();
        loaded  = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < n_instr; i++) begin
            in_op      = op_t'(st_op[i]);
            in_rs      = st_rs[i];
            in_rt      = st_rt[i];
            in_rd      = st_rd[i];
            in_imm     = st_imm[i];
            in_cp0_sel = cp0_sel_t'(st_sel[i]);
            in_valid   = 1'b1;
            @(posedge clk);
            while (!in_ready) @(posedge clk);    // held until the core takes it
            @(negedge clk);
        end
        in_valid = 1'b0;
        wait (retired == n_instr);
        repeat (4) @(posedge clk);
        end_run();
    end

    // watchdog scaled to the trace length
    initial begin
        wait (loaded);
        #(40 * (16 + 8 * n_instr + 20));
        errors++;
        $display("timeout with %0d of %0d instructions retired", retired, n_instr);
        end_run();
    end

endmodule

/* tests/operand_trace.txt */
# op rs rt rd imm cp0_sel exp_rd exp_data exp_cp0_we
# all fields hex, op 0 add 1 sub 2 and 3 or 4 xor 5 addi 6 lui 7 mfc0 8 mtc0, cp0_sel 0 ie 1 epc
7 00 00 01 0000 0 01 00000000 0
7 00 00 02 0000 1 02 00000000 0
5 00 00 03 1234 0 03 00001234 0
5 00 00 04 fff0 0 04 fffffff0 0
6 00 00 05 abcd 0 05 abcd0000 0
0 03 04 06 0000 0 06 00001224 0
1 06 05 07 0000 0 07 54331224 0
2 03 07 08 0000 0 08 00001224 0
3 08 05 09 0000 0 09 abcd1224 0
4 09 07 0a 0000 0 0a fffe0000 0
0 03 04 00 0000 0 00 00001224 0
0 00 0a 0b 0000 0 0b fffe0000 0
3 00 00 0c 0000 0 0c 00000000 0
0 00 03 0d 0000 0 0d 00001234 0
8 00 03 00 0000 0 00 00001234 1
7 00 00 0e 0000 0 0e 00001234 0
8 00 07 00 0000 1 00 54331224 1
0 03 03 0f 0000 0 0f 00002468 0
7 00 00 10 0000 1 10 54331224 0
8 00 0f 00 0000 0 00 00002468 1
1 0f 03 11 0000 0 11 00001234 0
4 03 03 12 0000 0 12 00000000 0
7 00 00 13 0000 0 13 00002468 0
8 00 09 00 0000 1 00 abcd1224 1
7 00 00 14 0000 1 14 abcd1224 0
8 00 0a 00 0000 0 00 fffe0000 1
2 09 0a 15 0000 0 15 abcc0000 0
7 00 00 16 0000 0 16 fffe0000 0
8 00 0d 00 0000 1 00 00001234 1
5 0d 00 17 0001 0 17 00001235 0
3 0d 0d 18 0000 0 18 00001234 0
7 00 00 19 0000 1 19 00001234 0

/* filelist.f */
rtl/isa_pkg.sv
rtl/fwd_pkg.sv
rtl/arch_regs.sv
rtl/fwd_ctrl.sv
rtl/cmb_forward.sv
rtl/pipe_reg.sv
rtl/exec_unit.sv
rtl/operand_core.sv
tests/operand_core_asserts.sv
tests/operand_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build with Verilator and run from the project root, pass is decided from sim.log
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -f filelist.f --top-module operand_core_tb \
    -o operand_core_sim --Mdir obj_dir &&
./obj_dir/operand_core_sim | tee sim.log &&
grep -qx "sim passed" sim.log &&
echo "PASS" || { echo "FAIL"; exit 1; }
